// File: rtl/periph_cfg.svh
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Core data bus
`define PERIPH_ADDR_W 11
`define PERIPH_DATA_W 32

// Output PMOD width
`define PERIPH_PINS 8

// Slots per class, user and simple
`define PERIPH_SLOTS 16

// Function select, top bit picks the simple class
`define GPIO_SEL_W 5

// Register offsets inside the GPIO slot
`define GPIO_OFS_OUT 6'h00
`define GPIO_OFS_IN 6'h04

`endif

// File: rtl/periph_pkg.sv
`default_nettype none

`include "periph_cfg.svh"

package periph_pkg;

    // Access size code used on both the read and the write strobe
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_e;

    // Fixed user slot assignments
    typedef enum logic [$clog2(`PERIPH_SLOTS)-1:0] {
        SLOT_RESERVED = 4'd0,
        SLOT_GPIO     = 4'd1,
        SLOT_UART     = 4'd2
    } user_slot_e;

    // Request from the core, held as a level
    typedef struct packed {
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] wdata;
        access_size_e              wr_size;
        access_size_e              rd_size;
    } periph_req_t;

    // Slot selection, also the layout of a function-select value
    typedef struct packed {
        logic                              is_simple;
        logic [$clog2(`PERIPH_SLOTS)-1:0]  idx;
    } slot_sel_t;

    // Read response from one slot
    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0] data;
        logic                      ready;
    } slot_resp_t;

endpackage

`default_nettype wire

// File: rtl/periph_addr_decode.sv
`default_nettype none

`include "periph_cfg.svh"

module periph_addr_decode (
    input  periph_pkg::periph_req_t i_req,
    input  periph_pkg::slot_resp_t  i_gpio_resp,
    output periph_pkg::slot_sel_t   o_sel,
    output logic                    o_gpio_sel,
    output periph_pkg::slot_resp_t  o_resp
);

    import periph_pkg::*;

    slot_sel_t sel;

    // Bit 10 splits the space into user and simple slots
    always_comb begin
        sel.is_simple = i_req.addr[10];
        if (i_req.addr[10]) begin
            // 16-byte simple slots
            sel.idx = i_req.addr[7:4];
        end else begin
            // 64-byte user slots
            sel.idx = i_req.addr[9:6];
        end
    end

    assign o_sel = sel;
    assign o_gpio_sel = !sel.is_simple && (user_slot_e'(sel.idx) == SLOT_GPIO);

    // Response mux
    always_comb begin
        o_resp.data  = '0;
        o_resp.ready = 1'b1;

        if (!sel.is_simple) begin
            case (user_slot_e'(sel.idx))
                SLOT_RESERVED: begin
                    // Reserved by the wrapper, never answers
                    o_resp.ready = 1'b0;
                end
                SLOT_GPIO: begin
                    o_resp = i_gpio_resp;
                end
                default: begin
                    // UART slot and unpopulated slots read as zero
                    o_resp.data  = '0;
                    o_resp.ready = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/periph_read_buffer.sv
`default_nettype none

`include "periph_cfg.svh"

module periph_read_buffer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  periph_pkg::periph_req_t  i_req,
    input  periph_pkg::slot_resp_t   i_resp,
    input  logic                     i_data_read_complete,
    output logic [`PERIPH_DATA_W-1:0] o_data_out,
    output logic                     o_data_ready
);

    import periph_pkg::*;

    logic                      read_req;
    logic                      write_req;
    logic                      capture;
    logic                      data_hold;
    logic                      data_ready_r;
    logic [`PERIPH_DATA_W-1:0] data_out_r;

    assign read_req  = i_req.rd_size != SIZE_NONE;
    assign write_req = i_req.wr_size != SIZE_NONE;

    // Take new data only while nothing is held for the core
    assign capture = read_req && i_resp.ready && !data_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold    <= 1'b0;
            data_ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                data_hold <= 1'b0;
            end
            // A capture in the same cycle wins over the release
            if (capture) begin
                data_hold <= 1'b1;
            end
            data_ready_r <= read_req && i_resp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_out_r <= i_resp.data;
        end
    end

    assign o_data_out = data_out_r;

    // Writes complete immediately
    assign o_data_ready = data_ready_r || write_req;

endmodule

`default_nettype wire

// File: rtl/gpio_regs.sv
`default_nettype none

`include "periph_cfg.svh"

module gpio_regs (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  periph_pkg::periph_req_t                    i_req,
    input  logic                                       i_gpio_sel,
    input  logic [`PERIPH_PINS-1:0]                    i_ui_in,
    output periph_pkg::slot_resp_t                     o_resp,
    output logic [`PERIPH_PINS-1:0]                    o_gpio_out,
    output logic [`PERIPH_PINS-1:0][`GPIO_SEL_W-1:0]   o_func_sel
);

    import periph_pkg::*;

    logic [5:0]                               ofs;
    logic                                     wr_en;
    logic                                     sel_hit;
    logic [$clog2(`PERIPH_PINS)-1:0]          sel_idx;
    logic [`PERIPH_PINS-1:0]                  gpio_out;
    logic [`PERIPH_PINS-1:0][`GPIO_SEL_W-1:0] func_sel;

    // Offset within the 64-byte slot
    assign ofs   = i_req.addr[5:0];
    assign wr_en = i_gpio_sel && (i_req.wr_size != SIZE_NONE);

    // Select registers sit at 0x20 + 4*i, word aligned
    assign sel_hit = ofs[5] && (ofs[1:0] == 2'b00);
    assign sel_idx = ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && (ofs == `GPIO_OFS_OUT)) begin
            gpio_out <= i_req.wdata[`PERIPH_PINS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PERIPH_PINS; i++) begin
                // Pins 0 and 1 belong to the UART out of reset
                if (i < 2) begin
                    func_sel[i] <= {1'b0, SLOT_UART};
                end else begin
                    func_sel[i] <= {1'b0, SLOT_GPIO};
                end
            end
        end else if (wr_en && sel_hit) begin
            for (int i = 0; i < `PERIPH_PINS; i++) begin
                if (sel_idx == i) begin
                    func_sel[i] <= i_req.wdata[`GPIO_SEL_W-1:0];
                end
            end
        end
    end

    // Read response, always ready
    always_comb begin
        o_resp.data  = '0;
        o_resp.ready = 1'b1;

        if (ofs == `GPIO_OFS_OUT) begin
            o_resp.data[`PERIPH_PINS-1:0] = gpio_out;
        end else if (ofs == `GPIO_OFS_IN) begin
            o_resp.data[`PERIPH_PINS-1:0] = i_ui_in;
        end else if (sel_hit) begin
            o_resp.data[`GPIO_SEL_W-1:0] = func_sel[sel_idx];
        end
    end

    assign o_gpio_out = gpio_out;
    assign o_func_sel = func_sel;

endmodule

`default_nettype wire

// File: rtl/pin_out_mux.sv
`default_nettype none

`include "periph_cfg.svh"

module pin_out_mux (
    input  logic [`PERIPH_PINS-1:0][`GPIO_SEL_W-1:0] i_func_sel,
    input  logic [`PERIPH_PINS-1:0]                  i_gpio_out,
    output logic [`PERIPH_PINS-1:0]                  o_uo_out
);

    import periph_pkg::*;

    slot_sel_t pin_sel [`PERIPH_PINS];

    // View each select value as a slot selection
    always_comb begin
        for (int i = 0; i < `PERIPH_PINS; i++) begin
            pin_sel[i] = slot_sel_t'(i_func_sel[i]);
        end
    end

    // Only the GPIO slot drives pins, everything else is low
    always_comb begin
        for (int i = 0; i < `PERIPH_PINS; i++) begin
            o_uo_out[i] = 1'b0;
            if (!pin_sel[i].is_simple && (user_slot_e'(pin_sel[i].idx) == SLOT_GPIO)) begin
                o_uo_out[i] = i_gpio_out[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/periph_bus_top.sv
`default_nettype none

`include "periph_cfg.svh"

module periph_bus_top (
    input  logic                      clk,
    input  logic                      rst_n,

    // PMOD pins
    input  logic [`PERIPH_PINS-1:0]   i_ui_in,
    output logic [`PERIPH_PINS-1:0]   o_uo_out,

    // Core data bus
    input  logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  logic [`PERIPH_DATA_W-1:0] i_data,
    input  periph_pkg::access_size_e  i_data_write_n,
    input  periph_pkg::access_size_e  i_data_read_n,
    output logic [`PERIPH_DATA_W-1:0] o_data_out,
    output logic                      o_data_ready,
    input  logic                      i_data_read_complete
);

    import periph_pkg::*;

    periph_req_t                              req;
    slot_resp_t                               gpio_resp;
    slot_resp_t                               slot_resp;
    logic                                     gpio_sel;
    logic [`PERIPH_PINS-1:0]                  gpio_out;
    logic [`PERIPH_PINS-1:0][`GPIO_SEL_W-1:0] func_sel;

    assign req.addr    = i_addr;
    assign req.wdata   = i_data;
    assign req.wr_size = i_data_write_n;
    assign req.rd_size = i_data_read_n;

    periph_read_buffer u_read_buffer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_req                (req),
        .i_resp               (slot_resp),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    // Selection is only needed for the response mux here
    periph_addr_decode u_addr_decode (
        .i_req       (req),
        .i_gpio_resp (gpio_resp),
        .o_sel       (),
        .o_gpio_sel  (gpio_sel),
        .o_resp      (slot_resp)
    );

    gpio_regs u_gpio_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (req),
        .i_gpio_sel (gpio_sel),
        .i_ui_in    (i_ui_in),
        .o_resp     (gpio_resp),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    pin_out_mux u_pin_out_mux (
        .i_func_sel (func_sel),
        .i_gpio_out (gpio_out),
        .o_uo_out   (o_uo_out)
    );

endmodule

`default_nettype wire

// File: testbench/tb_periph_bus.sv
`default_nettype none

`include "periph_cfg.svh"

module tb_periph_bus;

    timeunit 1ns;
    timeprecision 1ps;

    import periph_pkg::*;

    localparam int N_SEL_RESET = `PERIPH_PINS;
    localparam int N_WR        = 64;
    localparam int N_IN        = 16;
    localparam int N_UNPOP     = 48;
    // Slot 0 probe, held read and the read after its release
    localparam int N_MISC      = 3;
    localparam int N_TRANS     = N_SEL_RESET + 2 * N_WR + N_IN + N_UNPOP + N_MISC;
    localparam int TIMEOUT_CYCLES = 20 * N_TRANS;

    // GPIO lives in user slot 1, select registers from offset 0x20
    localparam logic [`PERIPH_ADDR_W-1:0] GPIO_BASE = 11'h040;
    localparam logic [`PERIPH_ADDR_W-1:0] SEL_BASE  = 11'h060;

    logic                      clk;
    logic                      rst_n;
    logic [`PERIPH_PINS-1:0]   ui_in;
    logic [`PERIPH_PINS-1:0]   uo_out;
    logic [`PERIPH_ADDR_W-1:0] addr;
    logic [`PERIPH_DATA_W-1:0] data_in;
    access_size_e              wr_size;
    access_size_e              rd_size;
    logic [`PERIPH_DATA_W-1:0] data_out;
    logic                      data_ready;
    logic                      read_complete;

    // Reference copy of the GPIO registers
    logic [`PERIPH_PINS-1:0]   model_out;
    logic [`GPIO_SEL_W-1:0]    model_sel [`PERIPH_PINS];

    int cycle_cnt;

    periph_bus_top DUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .i_addr               (addr),
        .i_data               (data_in),
        .i_data_write_n       (wr_size),
        .i_data_read_n        (rd_size),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .i_data_read_complete (read_complete)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped by the watchdog");
    end

    task automatic compare_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (expected !== actual) begin
            $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Check %s did not match", name);
        end
    endtask

    task automatic set_idle();
        addr          = '0;
        data_in       = '0;
        wr_size       = SIZE_NONE;
        rd_size       = SIZE_NONE;
        read_complete = 1'b0;
    endtask

    function automatic logic [`PERIPH_ADDR_W-1:0] sel_addr(input logic [2:0] pin);
        return {SEL_BASE[10:5], pin, 2'b00};
    endfunction

    // Pin shows its GPIO bit only when its select names user slot 1
    function automatic logic [`PERIPH_PINS-1:0] expected_pins();
        logic [`PERIPH_PINS-1:0] pins;
        pins = '0;
        for (int i = 0; i < `PERIPH_PINS; i++) begin
            if (model_sel[i] == 5'd1) begin
                pins[i] = model_out[i];
            end
        end
        return pins;
    endfunction

    function automatic logic [31:0] expected_read(input logic [`PERIPH_ADDR_W-1:0] a);
        logic [5:0]  ofs;
        logic [31:0] value;
        ofs   = a[5:0];
        value = '0;
        if (!a[10] && (a[9:6] == 4'd1)) begin
            if (ofs == `GPIO_OFS_OUT) begin
                value[7:0] = model_out;
            end else if (ofs == `GPIO_OFS_IN) begin
                value[7:0] = ui_in;
            end else if (ofs[5] && (ofs[1:0] == 2'b00)) begin
                value[4:0] = model_sel[ofs[4:2]];
            end
        end
        return value;
    endfunction

    // Ready is expected one clock after the request
    task automatic wait_for_ready();
        int cycles;
        @(negedge clk);
        cycles = 1;
        while (!data_ready) begin
            @(negedge clk);
            cycles++;
        end
        compare_value("read latency", 32'd1, cycles);
    endtask

    task automatic write_word(
        input logic [`PERIPH_ADDR_W-1:0] a,
        input logic [31:0]               d
    );
        addr    = a;
        data_in = d;
        wr_size = SIZE_WORD;
        @(negedge clk);
        compare_value("write ready", 32'd1, {31'd0, data_ready});
        set_idle();
        if (!a[10] && (a[9:6] == 4'd1)) begin
            if (a[5:0] == `GPIO_OFS_OUT) begin
                model_out = d[7:0];
            end else if (a[5] && (a[1:0] == 2'b00)) begin
                model_sel[a[4:2]] = d[4:0];
            end
        end
        compare_value("pins after write", {24'd0, expected_pins()}, {24'd0, uo_out});
    endtask

    task automatic read_word(
        input  logic [`PERIPH_ADDR_W-1:0] a,
        output logic [31:0]               d
    );
        addr    = a;
        rd_size = SIZE_WORD;
        wait_for_ready();
        d             = data_out;
        rd_size       = SIZE_NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
    endtask

    task automatic check_read(input string name, input logic [`PERIPH_ADDR_W-1:0] a);
        logic [31:0] got;
        logic [31:0] expected;
        expected = expected_read(a);
        read_word(a, got);
        compare_value(name, expected, got);
    endtask

    initial begin
        int                      seed;
        logic [31:0]             rnd;
        logic [31:0]             d;
        logic [31:0]             got;
        logic [`PERIPH_ADDR_W-1:0] a;
        logic [5:0]              ofs;
        logic [3:0]              idx;
        logic [2:0]              pin;
        logic [7:0]              held;

        seed = 32'h9f6c_c276;
        rnd  = $urandom(seed);

        rst_n = 1'b0;
        ui_in = '0;
        set_idle();
        model_out = '0;
        for (int i = 0; i < `PERIPH_PINS; i++) begin
            model_sel[i] = (i < 2) ? 5'd2 : 5'd1;
        end

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset values
        compare_value("idle ready after reset", 32'd0, {31'd0, data_ready});
        compare_value("pins after reset", 32'd0, {24'd0, uo_out});
        pin = '0;
        repeat (`PERIPH_PINS) begin
            read_word(sel_addr(pin), got);
            compare_value("select after reset", (pin < 3'd2) ? 32'd2 : 32'd1, got);
            pin = pin + 1'b1;
        end

        // Random GPIO writes, each read back
        repeat (N_WR) begin
            rnd = $urandom;
            d   = $urandom;
            if (!rnd[3]) begin
                a = GPIO_BASE;
            end else begin
                a = sel_addr(rnd[2:0]);
                case (rnd[5:4])
                    2'd0: d[4:0] = 5'h01;
                    2'd1: d[4:0] = 5'h02;
                    2'd2: d[4:0] = 5'h10;
                    default: d[4:0] = rnd[12:8];
                endcase
            end
            write_word(a, d);
            check_read("gpio readback", a);
        end

        // Input pin readback
        repeat (N_IN) begin
            rnd   = $urandom;
            ui_in = rnd[7:0];
            check_read("input readback", GPIO_BASE | 11'h004);
        end

        // Unpopulated slots and unmapped GPIO offsets
        repeat (N_UNPOP) begin
            rnd = $urandom;
            if (rnd[1:0] == 2'd0) begin
                idx = 4'd2 + 4'(rnd[7:4] % 4'd14);
                a   = {1'b0, idx, rnd[13:8]};
            end else if (rnd[1:0] == 2'd1) begin
                a     = rnd[26:16];
                a[10] = 1'b1;
            end else begin
                ofs = rnd[13:8];
                while ((ofs == 6'h00) || (ofs == 6'h04) || (ofs[5] && (ofs[1:0] == 2'b00))) begin
                    rnd = $urandom;
                    ofs = rnd[5:0];
                end
                a = GPIO_BASE | {5'd0, ofs};
            end
            read_word(a, got);
            compare_value("unpopulated read", 32'd0, got);
        end

        // Slot 0 never answers
        rnd     = $urandom;
        addr    = {1'b0, 4'd0, rnd[5:0]};
        rd_size = SIZE_WORD;
        repeat (10) begin
            @(negedge clk);
            compare_value("slot 0 ready", 32'd0, {31'd0, data_ready});
        end
        set_idle();
        @(negedge clk);

        // Captured data holds while the pins change
        rnd     = $urandom;
        ui_in   = rnd[7:0];
        held    = rnd[7:0];
        addr    = GPIO_BASE | 11'h004;
        rd_size = SIZE_WORD;
        wait_for_ready();
        compare_value("hold capture", {24'd0, held}, data_out);
        repeat (6) begin
            rnd   = $urandom;
            ui_in = held ^ (rnd[7:0] | 8'h01);
            @(negedge clk);
            compare_value("hold data", {24'd0, held}, data_out);
        end
        rd_size       = SIZE_NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        check_read("read after release", GPIO_BASE | 11'h004);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/periph_pkg.sv
rtl/periph_addr_decode.sv
rtl/periph_read_buffer.sv
rtl/gpio_regs.sv
rtl/pin_out_mux.sv
rtl/periph_bus_top.sv
testbench/tb_periph_bus.sv

// File: Bender.yml
package:
  name: periph_bus

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/periph_pkg.sv
      - rtl/periph_addr_decode.sv
      - rtl/periph_read_buffer.sv
      - rtl/gpio_regs.sv
      - rtl/pin_out_mux.sv
      - rtl/periph_bus_top.sv
  - target: test
    files:
      - testbench/tb_periph_bus.sv
